/* include/jtag_defines.svh */
`ifndef JTAG_DEFINES_SVH
`define JTAG_DEFINES_SVH

// command codes on the sequencer to TAP engine bus
`define CMD_JTAG_CLOSE_TEST 4'h0
`define CMD_JTAG_RUN_TEST   4'h1
`define CMD_JTAG_LOAD_IR    4'h2
`define CMD_JTAG_LOAD_DR    4'h3

// tms high steps, reaches test-logic-reset from any state
`define JTAG_CLOSE_STEPS 5

// instruction register of the attached device
`define JTAG_IR_LEN    10
`define JTAG_IR_IDCODE 10'h009

// idcode register
`define JTAG_DR_LEN 32

// part code check on bits 27:0, version nibble ignored
`define JTAG_IDCODE_MASK  28'hfff_ffff
`define JTAG_IDCODE_MATCH 28'h060_2899

`define FIFO_DEPTH 64 // tdi bits, holds ir + dr stream

`endif

/* hw/jtag_pkg.sv */
package jtag_pkg;

    typedef logic [3:0]  jtag_cmd_t;  // command code
    typedef logic [15:0] cycle_cnt_t; // shift bits or idle steps
    typedef logic [31:0] idcode_t;

    // ieee 1149.1 tap states, standard encoding
    typedef enum logic [3:0] {
        TAP_EXIT2_DR = 4'h0,
        TAP_EXIT1_DR = 4'h1,
        TAP_SHIFT_DR = 4'h2,
        TAP_PAUSE_DR = 4'h3,
        TAP_SEL_IR   = 4'h4,
        TAP_UPD_DR   = 4'h5,
        TAP_CAP_DR   = 4'h6,
        TAP_SEL_DR   = 4'h7,
        TAP_EXIT2_IR = 4'h8,
        TAP_EXIT1_IR = 4'h9,
        TAP_SHIFT_IR = 4'ha,
        TAP_PAUSE_IR = 4'hb,
        TAP_IDLE     = 4'hc,
        TAP_UPD_IR   = 4'hd,
        TAP_CAP_IR   = 4'he,
        TAP_RESET    = 4'hf
    } tap_state_t;

endpackage

/* hw/jtag_cmd_if.sv */
`timescale 1ns/1ps

interface jtag_cmd_if import jtag_pkg::*; ();

    jtag_cmd_t  cmd;
    cycle_cnt_t cycle_num;
    logic       cmd_valid;
    logic       cmd_ready; // low while a command runs
    logic       cmd_done;  // one cycle at end of command

    modport seq (
        output cmd, cycle_num, cmd_valid,
        input  cmd_ready, cmd_done
    );

    modport engine (
        input  cmd, cycle_num, cmd_valid,
        output cmd_ready, cmd_done
    );

endinterface

/* hw/jtag_shift_if.sv */
`timescale 1ns/1ps

interface jtag_shift_if ();

    logic shift_in;    // fifo head, next tdi bit
    logic shift_ready; // fifo not empty
    logic tap_shift;   // strobe per shifted bit
    logic shift_out;   // tdo of the same bit

    modport fifo (output shift_in, shift_ready, input tap_shift);

    modport engine (input shift_in, shift_ready, output tap_shift, shift_out);

    modport capture (input tap_shift, shift_out);

endinterface

/* hw/jtag_cmd_seq.sv */
`timescale 1ns/1ps
`include "jtag_defines.svh"

module jtag_cmd_seq import jtag_pkg::*; (
    input  logic    clk_jtag,
    input  logic    rst,
    jtag_cmd_if.seq cmd_bus,
    output logic    wr_en,
    output logic    wr_bit,
    output logic    capture,
    output logic    seq_done
);

    localparam int         NUM_BITS     = `JTAG_IR_LEN + `JTAG_DR_LEN;
    localparam logic [2:0] LAST_STEP    = 3'd5;
    localparam logic [2:0] DR_DONE_STEP = 3'd5; // load_dr is the one in flight
    localparam logic [2:0] END_STEP     = 3'd6;

    logic [2:0]          step;     // next command to issue
    logic [5:0]          wr_cnt;   // tdi bits already written
    logic [NUM_BITS-1:0] tdi_bits;
    logic                accept;

    assign accept  = cmd_bus.cmd_valid && cmd_bus.cmd_ready;
    assign wr_bit  = tdi_bits[0]; // lsb goes out first
    assign capture = cmd_bus.cmd_done && (step == DR_DONE_STEP);

    // idcode read list
    always_comb begin
        case (step)
            3'd1, 3'd3: begin
                cmd_bus.cmd       = `CMD_JTAG_RUN_TEST;
                cmd_bus.cycle_num = '0;
            end
            3'd2: begin
                cmd_bus.cmd       = `CMD_JTAG_LOAD_IR;
                cmd_bus.cycle_num = cycle_cnt_t'(`JTAG_IR_LEN);
            end
            3'd4: begin
                cmd_bus.cmd       = `CMD_JTAG_LOAD_DR;
                cmd_bus.cycle_num = cycle_cnt_t'(`JTAG_DR_LEN);
            end
            default: begin
                cmd_bus.cmd       = `CMD_JTAG_CLOSE_TEST;
                cmd_bus.cycle_num = '0;
            end
        endcase
    end

    always_ff @(posedge clk_jtag) begin
        if (rst) begin
            step              <= '0;
            cmd_bus.cmd_valid <= 1'b0;
            seq_done          <= 1'b0;
        end else begin
            if (accept)
                step <= step + 3'd1;
            cmd_bus.cmd_valid <= accept ? (step < LAST_STEP) : (step <= LAST_STEP);
            if (cmd_bus.cmd_done && step == END_STEP)
                seq_done <= 1'b1; // close_test finished
        end
    end

    // ir instruction then dr zeros, one bit per cycle
    always_ff @(posedge clk_jtag) begin
        if (rst) begin
            wr_cnt   <= '0;
            wr_en    <= 1'b0;
            tdi_bits <= {{`JTAG_DR_LEN{1'b0}}, `JTAG_IR_IDCODE};
        end else begin
            if (wr_en) begin
                wr_cnt   <= wr_cnt + 6'd1;
                tdi_bits <= tdi_bits >> 1;
            end
            wr_en <= wr_en ? (wr_cnt != 6'(NUM_BITS - 1)) : (wr_cnt == '0);
        end
    end

endmodule

/* hw/tap_engine.sv */
`timescale 1ns/1ps
`include "jtag_defines.svh"

module tap_engine import jtag_pkg::*; (
    input  logic         clk_jtag,
    input  logic         rst,
    jtag_cmd_if.engine   cmd_bus,
    jtag_shift_if.engine sh,
    output logic         tck,
    output logic         tms,
    output logic         tdi,
    input  logic         tdo
);

    tap_state_t state;
    jtag_cmd_t  cmd_q;
    cycle_cnt_t lim_q;
    cycle_cnt_t cnt;      // steps, idle steps or shifted bits
    logic       busy;
    logic       tdi_vld;  // tdi holds the fifo head
    logic       in_shift;
    logic       cmd_fin;
    logic       cnt_inc;
    logic       step_go;

    function automatic tap_state_t tap_next(input tap_state_t s, input logic m);
        case (s)
            TAP_RESET:    return m ? TAP_RESET    : TAP_IDLE;
            TAP_IDLE:     return m ? TAP_SEL_DR   : TAP_IDLE;
            TAP_SEL_DR:   return m ? TAP_SEL_IR   : TAP_CAP_DR;
            TAP_CAP_DR:   return m ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR: return m ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR: return m ? TAP_UPD_DR   : TAP_PAUSE_DR;
            TAP_PAUSE_DR: return m ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR: return m ? TAP_UPD_DR   : TAP_SHIFT_DR;
            TAP_UPD_DR:   return m ? TAP_SEL_DR   : TAP_IDLE;
            TAP_SEL_IR:   return m ? TAP_RESET    : TAP_CAP_IR;
            TAP_CAP_IR:   return m ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR: return m ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR: return m ? TAP_UPD_IR   : TAP_PAUSE_IR;
            TAP_PAUSE_IR: return m ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR: return m ? TAP_UPD_IR   : TAP_SHIFT_IR;
            TAP_UPD_IR:   return m ? TAP_SEL_DR   : TAP_IDLE;
            default:      return TAP_RESET;
        endcase
    endfunction

    // tms for the next step of command c
    function automatic logic step_tms(input jtag_cmd_t c, input tap_state_t s,
                                      input cycle_cnt_t n, input cycle_cnt_t lim);
        if (c == `CMD_JTAG_CLOSE_TEST)
            return 1'b1;
        case (s)
            TAP_RESET, TAP_CAP_DR, TAP_CAP_IR, TAP_UPD_DR, TAP_UPD_IR: return 1'b0;
            TAP_IDLE:                   return c != `CMD_JTAG_RUN_TEST;
            TAP_SEL_DR:                 return c != `CMD_JTAG_LOAD_DR;
            TAP_SEL_IR:                 return c != `CMD_JTAG_LOAD_IR;
            TAP_SHIFT_DR, TAP_SHIFT_IR: return n == lim - 1'b1; // exit on last bit
            default:                    return 1'b1;
        endcase
    endfunction

    assign busy     = !cmd_bus.cmd_ready;
    assign in_shift = (state == TAP_SHIFT_DR) || (state == TAP_SHIFT_IR);
    assign cmd_fin  = (cmd_q == `CMD_JTAG_CLOSE_TEST) ?
                      (cnt == cycle_cnt_t'(`JTAG_CLOSE_STEPS)) :
                      (state == TAP_IDLE && cnt == lim_q);
    assign cnt_inc  = (cmd_q == `CMD_JTAG_CLOSE_TEST) || in_shift ||
                      (cmd_q == `CMD_JTAG_RUN_TEST && state == TAP_IDLE);
    assign step_go  = busy && !tck && !cmd_fin && (!in_shift || tdi_vld); // stall on empty fifo

    assign sh.tap_shift = step_go && in_shift; // pops the bit on tdi
    assign sh.shift_out = tdo;                 // driven by target on falling tck

    always_ff @(posedge clk_jtag) begin
        if (rst) begin
            state             <= TAP_RESET;
            tck               <= 1'b0;
            tms               <= 1'b1;
            tdi               <= 1'b0;
            tdi_vld           <= 1'b0;
            cnt               <= '0;
            cmd_bus.cmd_ready <= 1'b1;
            cmd_bus.cmd_done  <= 1'b0;
        end else begin
            cmd_bus.cmd_done <= 1'b0;
            if (!busy) begin
                if (cmd_bus.cmd_valid) begin
                    cmd_q             <= cmd_bus.cmd;
                    lim_q             <= cmd_bus.cycle_num;
                    cnt               <= '0;
                    cmd_bus.cmd_ready <= 1'b0;
                    tms <= step_tms(cmd_bus.cmd, state, '0, cmd_bus.cycle_num);
                end
            end else if (tck) begin // falling tck, set up next step
                tck <= 1'b0;
                tms <= step_tms(cmd_q, state, cnt, lim_q);
                if (in_shift && sh.shift_ready) begin
                    tdi     <= sh.shift_in;
                    tdi_vld <= 1'b1;
                end
            end else if (cmd_fin) begin
                cmd_bus.cmd_ready <= 1'b1;
                cmd_bus.cmd_done  <= 1'b1;
            end else if (step_go) begin // rising tck
                tck     <= 1'b1;
                state   <= tap_next(state, tms);
                tdi_vld <= 1'b0;
                if (cnt_inc)
                    cnt <= cnt + 1'b1;
            end else if (in_shift && sh.shift_ready) begin
                tdi     <= sh.shift_in; // bit arrived while stalled
                tdi_vld <= 1'b1;
            end
        end
    end

endmodule

/* hw/shift_bit_fifo.sv */
`timescale 1ns/1ps
`include "jtag_defines.svh"

module shift_bit_fifo (
    input  logic       clk_jtag,
    input  logic       rst,
    input  logic       wr_en,
    input  logic       wr_bit,
    jtag_shift_if.fifo sh
);

    localparam int          AW   = $clog2(`FIFO_DEPTH);
    localparam logic [AW:0] FULL = `FIFO_DEPTH;

    logic          mem [`FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign do_wr = wr_en && (count != FULL); // dropped when full
    assign do_rd = sh.tap_shift && (count != '0);

    assign sh.shift_in    = mem[rd_ptr];
    assign sh.shift_ready = (count != '0);

    always_ff @(posedge clk_jtag) begin
        if (do_wr)
            mem[wr_ptr] <= wr_bit;
    end

    always_ff @(posedge clk_jtag) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{AW{1'b0}}, do_wr} - {{AW{1'b0}}, do_rd};
        end
    end

endmodule

/* hw/idcode_capture.sv */
`timescale 1ns/1ps
`include "jtag_defines.svh"

module idcode_capture import jtag_pkg::*; (
    input  logic          clk_jtag,
    input  logic          rst,
    input  logic          capture,
    jtag_shift_if.capture sh,
    output idcode_t       idcode,
    output logic          idcode_valid,
    output logic          init_done
);

    idcode_t shreg; // last 32 bits out of tdo

    always_ff @(posedge clk_jtag) begin
        if (sh.tap_shift)
            shreg <= {sh.shift_out, shreg[31:1]}; // lsb arrives first
        if (capture)
            idcode <= shreg;
    end

    always_ff @(posedge clk_jtag) begin
        if (rst) begin
            idcode_valid <= 1'b0;
            init_done    <= 1'b0;
        end else if (capture) begin
            idcode_valid <= 1'b1;
            init_done    <= (shreg[27:0] & `JTAG_IDCODE_MASK) ==
                            (`JTAG_IDCODE_MATCH & `JTAG_IDCODE_MASK);
        end
    end

endmodule

/* hw/jtag_idcode_top.sv */
`timescale 1ns/1ps

module jtag_idcode_top import jtag_pkg::*; (
    input  logic    clk_jtag,
    input  logic    rst,
    output logic    tck,
    output logic    tms,
    output logic    tdi,
    input  logic    tdo,
    output idcode_t idcode,
    output logic    idcode_valid,
    output logic    init_done,
    output logic    seq_done
);

    logic wr_en;
    logic wr_bit;
    logic capture;

    jtag_cmd_if   cmd_bus ();
    jtag_shift_if sh_bus ();

    jtag_cmd_seq seq_i (
        .clk_jtag (clk_jtag),
        .rst      (rst),
        .cmd_bus  (cmd_bus.seq),
        .wr_en    (wr_en),
        .wr_bit   (wr_bit),
        .capture  (capture),
        .seq_done (seq_done)
    );

    tap_engine tap_i (
        .clk_jtag (clk_jtag),
        .rst      (rst),
        .cmd_bus  (cmd_bus.engine),
        .sh       (sh_bus.engine),
        .tck      (tck),
        .tms      (tms),
        .tdi      (tdi),
        .tdo      (tdo)
    );

    shift_bit_fifo fifo_i (
        .clk_jtag (clk_jtag),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_bit   (wr_bit),
        .sh       (sh_bus.fifo)
    );

    idcode_capture cap_i (
        .clk_jtag     (clk_jtag),
        .rst          (rst),
        .capture      (capture),
        .sh           (sh_bus.capture),
        .idcode       (idcode),
        .idcode_valid (idcode_valid),
        .init_done    (init_done)
    );

endmodule

/* tests/jtag_target_model.sv */
`timescale 1ns/1ps

module jtag_target_model (
    input  logic        tck,
    input  logic        tms,
    input  logic        tdi,
    output logic        tdo,
    input  logic [31:0] idcode_val,  // word loaded at capture-dr
    input  logic [9:0]  idcode_ir,   // instruction that selects idcode
    output logic        in_reset     // tap sits in test-logic-reset
);

    typedef enum logic [3:0] {
        TAP_EXIT2_DR, TAP_EXIT1_DR, TAP_SHIFT_DR, TAP_PAUSE_DR,
        TAP_SEL_IR,   TAP_UPD_DR,   TAP_CAP_DR,   TAP_SEL_DR,
        TAP_EXIT2_IR, TAP_EXIT1_IR, TAP_SHIFT_IR, TAP_PAUSE_IR,
        TAP_IDLE,     TAP_UPD_IR,   TAP_CAP_IR,   TAP_RESET
    } tap_state_t;

    tap_state_t  state  = TAP_RESET;
    logic [9:0]  ir     = '1;     // all ones is bypass
    logic [9:0]  ir_sr  = '0;
    logic [31:0] dr_sr  = '0;
    logic        bypass = 1'b0;
    logic        tdo_q  = 1'b0;
    logic        sel_id;

    assign sel_id   = (ir == idcode_ir); // any other code acts as bypass
    assign in_reset = (state == TAP_RESET);
    assign tdo      = tdo_q;

    always @(posedge tck) begin
        case (state)
            TAP_CAP_IR:   ir_sr <= 10'b00_0000_0001;
            TAP_SHIFT_IR: ir_sr <= {tdi, ir_sr[9:1]};
            TAP_CAP_DR:   if (sel_id) dr_sr <= idcode_val; else bypass <= 1'b0;
            TAP_SHIFT_DR: if (sel_id) dr_sr <= {tdi, dr_sr[31:1]}; else bypass <= tdi;
            default: ;
        endcase
        case (state)
            TAP_RESET:    state <= tms ? TAP_RESET    : TAP_IDLE;
            TAP_IDLE:     state <= tms ? TAP_SEL_DR   : TAP_IDLE;
            TAP_SEL_DR:   state <= tms ? TAP_SEL_IR   : TAP_CAP_DR;
            TAP_CAP_DR:   state <= tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR: state <= tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR: state <= tms ? TAP_UPD_DR   : TAP_PAUSE_DR;
            TAP_PAUSE_DR: state <= tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR: state <= tms ? TAP_UPD_DR   : TAP_SHIFT_DR;
            TAP_SEL_IR:   state <= tms ? TAP_RESET    : TAP_CAP_IR;
            TAP_CAP_IR:   state <= tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR: state <= tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR: state <= tms ? TAP_UPD_IR   : TAP_PAUSE_IR;
            TAP_PAUSE_IR: state <= tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR: state <= tms ? TAP_UPD_IR   : TAP_SHIFT_IR;
            default:      state <= tms ? TAP_SEL_DR   : TAP_IDLE; // both update states
        endcase
    end

    always @(negedge tck) begin
        if (state == TAP_RESET)
            ir <= '1;
        else if (state == TAP_UPD_IR)
            ir <= ir_sr;
        if (state == TAP_SHIFT_IR)
            tdo_q <= ir_sr[0];
        else if (state == TAP_SHIFT_DR)
            tdo_q <= sel_id ? dr_sr[0] : bypass;
    end

endmodule

/* tests/jtag_idcode_assert.sv */
`timescale 1ns/1ps

module jtag_idcode_assert import jtag_pkg::*; (
    input logic       clk_jtag,
    input logic       rst,
    input logic       tck,
    input logic       tms,
    input logic       tdi,
    input logic       cmd_ready,
    input logic       cmd_done,
    input logic       tap_shift,
    input tap_state_t state
);

    a_pins_stable: assert property (@(posedge clk_jtag) disable iff (rst)
        tck |-> $stable(tms) && $stable(tdi))
        else $error("tms or tdi changed while tck was high");

    a_done_pulse: assert property (@(posedge clk_jtag) disable iff (rst)
        cmd_done |=> !cmd_done)
        else $error("cmd_done held for more than one cycle");

    // strobe marks a rising tck step out of shift-ir or shift-dr
    a_shift_state: assert property (@(posedge clk_jtag) disable iff (rst)
        tap_shift |=> $rose(tck) &&
            ($past(state) == TAP_SHIFT_DR || $past(state) == TAP_SHIFT_IR) &&
            (state == TAP_SHIFT_DR || state == TAP_EXIT1_DR ||
             state == TAP_SHIFT_IR || state == TAP_EXIT1_IR))
        else $error("tap_shift outside a tck step in shift-ir or shift-dr");

    a_ready_after_rst: assert property (@(posedge clk_jtag)
        $fell(rst) |-> cmd_ready)
        else $error("cmd_ready low in the first cycle after reset");

endmodule

bind tap_engine jtag_idcode_assert tap_chk_i (
    .clk_jtag  (clk_jtag),
    .rst       (rst),
    .tck       (tck),
    .tms       (tms),
    .tdi       (tdi),
    .cmd_ready (cmd_bus.cmd_ready),
    .cmd_done  (cmd_bus.cmd_done),
    .tap_shift (sh.tap_shift),
    .state     (state)
);

/* tests/tb_jtag_idcode.sv */
`timescale 1ns/1ps
`include "jtag_defines.svh"

module tb_jtag_idcode import jtag_pkg::*; ();

    localparam int NUM_FIXED    = 5;
    localparam int NUM_ROWS     = 9;
    localparam int DONE_TIMEOUT = 2000; // clk_jtag cycles

    typedef struct packed {
        idcode_t    id;       // model idcode
        logic [9:0] ir;       // model idcode instruction
        idcode_t    exp_id;
        logic       exp_init;
    } case_t;

    logic       clk_jtag;
    logic       rst;
    logic       tck;
    logic       tms;
    logic       tdi;
    logic       tdo;
    idcode_t    idcode;
    logic       idcode_valid;
    logic       init_done;
    logic       seq_done;
    idcode_t    model_id;
    logic [9:0] model_ir;
    logic       model_tlr;
    int         tms_ones = 0; // trailing tms highs seen at rising tck
    case_t      cases [NUM_ROWS];

    jtag_idcode_top dut_i (
        .clk_jtag     (clk_jtag),
        .rst          (rst),
        .tck          (tck),
        .tms          (tms),
        .tdi          (tdi),
        .tdo          (tdo),
        .idcode       (idcode),
        .idcode_valid (idcode_valid),
        .init_done    (init_done),
        .seq_done     (seq_done)
    );

    jtag_target_model target_i (
        .tck        (tck),
        .tms        (tms),
        .tdi        (tdi),
        .tdo        (tdo),
        .idcode_val (model_id),
        .idcode_ir  (model_ir),
        .in_reset   (model_tlr)
    );

    initial begin
        clk_jtag = 1'b0;
        forever #50 clk_jtag = ~clk_jtag;
    end

    always @(posedge tck)
        tms_ones <= tms ? tms_ones + 1 : 0;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_idcode(input string name, input idcode_t got, input idcode_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic apply_reset();
        @(negedge clk_jtag);
        rst = 1'b1;
        repeat (4) @(negedge clk_jtag);
        check_flag("tck", tck, 1'b0); // reset values just before release
        check_flag("tms", tms, 1'b1);
        check_flag("idcode_valid", idcode_valid, 1'b0);
        check_flag("init_done", init_done, 1'b0);
        check_flag("seq_done", seq_done, 1'b0);
        rst = 1'b0;
    endtask

    task automatic wait_for_done();
        int n;
        n = 0;
        while (seq_done !== 1'b1) begin
            if (n == DONE_TIMEOUT)
                abort_run("timeout while waiting for seq_done");
            @(negedge clk_jtag);
            n++;
        end
    endtask

    initial begin
        logic [31:0] seed;
        idcode_t     rnd;
        rst      = 1'b1;
        model_id = '0;
        model_ir = `JTAG_IR_IDCODE;

        cases[0] = {32'h1060_2899, `JTAG_IR_IDCODE, 32'h1060_2899, 1'b1};
        cases[1] = {32'h5060_2899, `JTAG_IR_IDCODE, 32'h5060_2899, 1'b1}; // other version
        cases[2] = {32'h1060_289b, `JTAG_IR_IDCODE, 32'h1060_289b, 1'b0};
        cases[3] = {32'h1060_2899, 10'h002, 32'h0000_0000, 1'b0};         // bypass
        cases[4] = {32'h4ba0_0477, 10'h3fe, 32'h0000_0000, 1'b0};
        seed = 32'hced4;
        for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
            seed = lcg_next(seed);
            rnd  = seed;
            if (rnd[27:0] == `JTAG_IDCODE_MATCH)
                rnd[0] = ~rnd[0]; // keep part code off the match
            cases[i] = {rnd, `JTAG_IR_IDCODE, rnd, 1'b0};
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk_jtag);
            model_id = cases[i].id;
            model_ir = cases[i].ir;
            apply_reset();
            wait_for_done();
            compare_idcode("idcode", idcode, cases[i].exp_id);
            check_flag("idcode_valid", idcode_valid, 1'b1);
            check_flag("init_done", init_done, cases[i].exp_init);
            check_flag("tms", tms, 1'b1);
            check_flag("tms_five_ones", tms_ones >= 5, 1'b1);
            check_flag("target_in_reset", model_tlr, 1'b1);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hw/jtag_pkg.sv
hw/jtag_cmd_if.sv
hw/jtag_shift_if.sv
hw/jtag_cmd_seq.sv
hw/tap_engine.sv
hw/shift_bit_fifo.sv
hw/idcode_capture.sv
hw/jtag_idcode_top.sv
tests/jtag_target_model.sv
tests/jtag_idcode_assert.sv
tests/tb_jtag_idcode.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f list.f --top-module tb_jtag_idcode \
    -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }

grep -q '\*\*\* TEST PASSED \*\*\*' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; cat sim.log; exit 1; }
